//--- rtl/fp_fwd_pkg.sv
// ==============================
// FP forwarding package
// Register address type, instruction views and defaults
// ==============================
package fp_fwd_pkg;

  // All 32 FP registers are writable, so there is no zero register to mask
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned INSTR_W = 32;

  // Default FP data width, single precision
  localparam int unsigned FLEN_DEFAULT = 32;

  typedef logic [REG_ADDR_W-1:0] fp_reg_addr_t;

  // ==============================
  // Instruction word views
  // ==============================
  // The R view supplies rs1 and rs2 for every FP op
  // The R4 view supplies rs3 for the fused multiply-add group
  typedef union packed {
    struct packed {
      logic [6:0]   funct7;
      fp_reg_addr_t rs2;
      fp_reg_addr_t rs1;
      logic [2:0]   funct3;
      fp_reg_addr_t rd;
      logic [6:0]   opcode;
    } r;
    struct packed {
      fp_reg_addr_t rs3;
      logic [1:0]   fmt;
      fp_reg_addr_t rs2;
      fp_reg_addr_t rs1;
      logic [2:0]   rm;
      fp_reg_addr_t rd;
      logic [6:0]   opcode;
    } r4;
  } fp_instr_u;

endpackage

//--- rtl/fp_fwd_ctrl.sv
// ==============================
// FP forwarding control
// Forward flags, pending stall, load-use history and load capture state
// ==============================
`timescale 1ns/100ps

module fp_fwd_ctrl import fp_fwd_pkg::*; (
  input  logic         i_clk,
  input  logic         i_rst_n,
  input  logic         i_stall,
  input  logic         i_flush,
  input  logic         i_load_use_stall,
  input  logic         i_load_ma_stall,
  input  fp_reg_addr_t i_pd_rs1,
  input  fp_reg_addr_t i_pd_rs2,
  input  fp_reg_addr_t i_pd_rs3,
  input  logic         i_ex_fp_we,
  input  logic         i_ex_is_fp_load,
  input  fp_reg_addr_t i_ex_dest,
  input  logic         i_ma_fp_we,
  input  logic         i_ma_is_fp_load,
  input  fp_reg_addr_t i_ma_dest,
  input  logic         i_ma_load_valid,
  output logic [2:0]   o_ma_fwd,
  output logic [2:0]   o_wb_fwd,
  output logic         o_stage1_en,
  output logic         o_stage1_sel_load,
  output logic         o_pending,
  output logic         o_load_use_q,
  output logic         o_cap_en,
  output logic         o_cap_valid
);

  fp_reg_addr_t pd_rs [3];
  logic         flag_update;
  logic [2:0]   ma_fwd_next;
  logic [2:0]   wb_fwd_next;
  logic         pending_q;
  logic         cap_clear_q;

  assign pd_rs[0] = i_pd_rs1;
  assign pd_rs[1] = i_pd_rs2;
  assign pd_rs[2] = i_pd_rs3;

  // ==============================
  // Forward flags
  // ==============================
  // The load-in-MA stall holds the consumer in ID, so the flags must still
  // be refreshed during that stall to be ready when the consumer moves on
  assign flag_update = ~i_stall | i_load_ma_stall;

  always_comb begin
    for (int k = 0; k < 3; k++) begin
      if (i_load_ma_stall) begin
        // The producing load already sits in MA
        ma_fwd_next[k] = i_ma_is_fp_load && (i_ma_dest == pd_rs[k]);
      end else begin
        ma_fwd_next[k] = (i_ex_fp_we || i_ex_is_fp_load) && (i_ex_dest == pd_rs[k]);
      end
      // WB forwarding looks one stage further on in both cases
      wb_fwd_next[k] = i_ma_fp_we && (i_ma_dest == pd_rs[k]);
    end
  end

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_ma_fwd <= '0;
      o_wb_fwd <= '0;
    end else if (i_flush) begin
      // Flush wins over any update in the same cycle
      o_ma_fwd <= '0;
      o_wb_fwd <= '0;
    end else if (flag_update) begin
      o_ma_fwd <= ma_fwd_next;
      o_wb_fwd <= wb_fwd_next;
    end
  end

  // ==============================
  // Stage-1 capture and pending
  // ==============================
  // Load data has priority over the EX result during a load-use stall
  assign o_stage1_sel_load = i_load_use_stall && i_ma_is_fp_load;
  assign o_stage1_en       = o_stage1_sel_load || (~i_stall && i_ex_fp_we);

  // Pending lasts one cycle, a capture that lands during it is dropped
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pending_q <= 1'b0;
    end else if (pending_q) begin
      pending_q <= 1'b0;
    end else if (o_stage1_en) begin
      pending_q <= 1'b1;
    end
  end

  assign o_pending = pending_q;

  // Remember the load-use stall so the selectors use the stage-2 copy
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_load_use_q <= 1'b0;
    end else begin
      o_load_use_q <= i_load_use_stall;
    end
  end

  // ==============================
  // One-entry load capture
  // ==============================
  assign o_cap_en = i_ma_is_fp_load && i_ma_load_valid;

  // The entry survives until the second edge after the stall is first seen low
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cap_valid <= 1'b0;
      cap_clear_q <= 1'b0;
    end else if (o_cap_en) begin
      o_cap_valid <= 1'b1;
      cap_clear_q <= 1'b0;
    end else if (o_cap_valid) begin
      if (cap_clear_q) begin
        o_cap_valid <= 1'b0;
        cap_clear_q <= 1'b0;
      end else if (~i_stall) begin
        cap_clear_q <= 1'b1;
      end
    end
  end

  // The forwarding stall is a single-cycle pulse
  a_pending_single: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) pending_q |=> !pending_q);

  // A capture entry only appears after a valid FP load in MA
  a_cap_valid_source: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) $rose(o_cap_valid) |-> $past(o_cap_en));

endmodule

//--- rtl/fp_fwd_data_pipe.sv
// ==============================
// FP forwarding data pipe
// Two-stage MA forward data and the load capture entry
// ==============================
`timescale 1ns/100ps

module fp_fwd_data_pipe import fp_fwd_pkg::*; #(
  parameter int unsigned FLEN = FLEN_DEFAULT
) (
  input  logic            i_clk,
  input  logic            i_rst_n,
  input  logic            i_stage1_en,
  input  logic            i_stage1_sel_load,
  input  logic            i_pending,
  input  logic            i_cap_en,
  input  logic [FLEN-1:0] i_ex_result,
  input  logic [FLEN-1:0] i_ma_load_data,
  input  fp_reg_addr_t    i_ma_dest,
  output logic [FLEN-1:0] o_stage2_data,
  output fp_reg_addr_t    o_cap_dest,
  output logic [FLEN-1:0] o_cap_data
);

  logic [FLEN-1:0] stage1_q;

  // ==============================
  // MA forward data stages
  // ==============================
  // Stage 1 takes the raw value, stage 2 drives the wide operand muxes
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      stage1_q <= '0;
    end else if (i_stage1_en) begin
      stage1_q <= i_stage1_sel_load ? i_ma_load_data : i_ex_result;
    end
  end

  // Data moves on during the one-cycle forwarding stall
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_stage2_data <= '0;
    end else if (i_pending) begin
      o_stage2_data <= stage1_q;
    end
  end

  // Destination and data of the most recent completed FP load
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_cap_dest <= '0;
      o_cap_data <= '0;
    end else if (i_cap_en) begin
      o_cap_dest <= i_ma_dest;
      o_cap_data <= i_ma_load_data;
    end
  end

  // A load select from the controller always comes with a capture
  a_sel_load_has_en: assert property (
    @(posedge i_clk) disable iff (!i_rst_n) i_stage1_sel_load |-> i_stage1_en);

endmodule

//--- rtl/fp_fwd_operand_sel.sv
// ==============================
// FP operand selector
// Priority forwarding mux for one source register
// ==============================
`timescale 1ns/100ps

module fp_fwd_operand_sel import fp_fwd_pkg::*; #(
  parameter int unsigned FLEN = FLEN_DEFAULT
) (
  input  fp_reg_addr_t    i_addr,
  input  logic            i_ma_fwd,
  input  logic            i_wb_fwd,
  input  logic            i_load_use_q,
  input  logic            i_cap_valid,
  input  fp_reg_addr_t    i_cap_dest,
  input  logic [FLEN-1:0] i_cap_data,
  input  logic [FLEN-1:0] i_stage2_data,
  input  logic            i_ma_fp_we,
  input  logic            i_ma_is_fp_load,
  input  fp_reg_addr_t    i_ma_dest,
  input  logic [FLEN-1:0] i_ma_result,
  input  logic [FLEN-1:0] i_ma_load_data,
  input  fp_reg_addr_t    i_wb_dest,
  input  logic [FLEN-1:0] i_wb_data,
  input  logic [FLEN-1:0] i_rf_data,
  output logic [FLEN-1:0] o_value
);

  logic ma_dest_hit;
  logic wb_dest_hit;
  logic cap_dest_hit;

  // Live address compares keep stale registered flags from forwarding
  assign ma_dest_hit  = (i_ma_dest == i_addr);
  assign wb_dest_hit  = (i_wb_dest == i_addr);
  assign cap_dest_hit = i_cap_valid && (i_cap_dest == i_addr);

  always_comb begin
    if (i_ma_is_fp_load && ma_dest_hit) begin
      // After a load-use stall the load data already sits in stage 2
      o_value = i_load_use_q ? i_stage2_data : i_ma_load_data;
    end else if (i_ma_fp_we && !i_ma_is_fp_load && ma_dest_hit) begin
      o_value = i_ma_result;
    end else if (i_ma_fwd && ma_dest_hit) begin
      o_value = i_stage2_data;
    end else if (i_wb_fwd && wb_dest_hit) begin
      o_value = i_wb_data;
    end else if (cap_dest_hit) begin
      // Load already left MA but the consumer arrived late
      o_value = i_cap_data;
    end else begin
      o_value = i_rf_data;
    end
  end

endmodule

//--- rtl/fp_fwd_unit.sv
// ==============================
// FP forwarding unit
// RAW hazard resolution for the three FP source operands
// ==============================
`timescale 1ns/100ps

module fp_fwd_unit import fp_fwd_pkg::*; #(
  parameter int unsigned FLEN = FLEN_DEFAULT
) (
  input  logic               i_clk,
  input  logic               i_rst_n,
  // Pipeline control
  input  logic               i_stall,
  input  logic               i_flush,
  input  logic               i_load_use_stall,
  input  logic               i_load_ma_stall,
  // Early source addresses from PD
  input  fp_reg_addr_t       i_pd_rs1,
  input  fp_reg_addr_t       i_pd_rs2,
  input  fp_reg_addr_t       i_pd_rs3,
  // Consumer in EX
  input  logic [INSTR_W-1:0] i_ex_instr,
  input  logic [FLEN-1:0]    i_ex_rf_rs1,
  input  logic [FLEN-1:0]    i_ex_rf_rs2,
  input  logic [FLEN-1:0]    i_ex_rf_rs3,
  // Producer in EX
  input  logic               i_ex_fp_we,
  input  logic               i_ex_is_fp_load,
  input  fp_reg_addr_t       i_ex_dest,
  input  logic [FLEN-1:0]    i_ex_result,
  // MA stage
  input  logic               i_ma_fp_we,
  input  logic               i_ma_is_fp_load,
  input  fp_reg_addr_t       i_ma_dest,
  input  logic [FLEN-1:0]    i_ma_result,
  input  logic [FLEN-1:0]    i_ma_load_data,
  input  logic               i_ma_load_valid,
  // WB stage
  input  fp_reg_addr_t       i_wb_dest,
  input  logic [FLEN-1:0]    i_wb_data,
  output logic [FLEN-1:0]    o_rs1_value,
  output logic [FLEN-1:0]    o_rs2_value,
  output logic [FLEN-1:0]    o_rs3_value,
  output logic               o_fwd_stall
);

  fp_instr_u       ex_instr;
  fp_reg_addr_t    src_addr [3];
  logic [FLEN-1:0] rf_data  [3];
  logic [FLEN-1:0] op_value [3];
  logic [2:0]      ma_fwd;
  logic [2:0]      wb_fwd;
  logic            stage1_en;
  logic            stage1_sel_load;
  logic            pending;
  logic            load_use_q;
  logic            cap_en;
  logic            cap_valid;
  fp_reg_addr_t    cap_dest;
  logic [FLEN-1:0] cap_data;
  logic [FLEN-1:0] stage2_data;

  // rs3 lives in the top five bits, which the R view calls funct7
  assign ex_instr    = i_ex_instr;
  assign src_addr[0] = ex_instr.r.rs1;
  assign src_addr[1] = ex_instr.r.rs2;
  assign src_addr[2] = ex_instr.r4.rs3;

  assign rf_data[0] = i_ex_rf_rs1;
  assign rf_data[1] = i_ex_rf_rs2;
  assign rf_data[2] = i_ex_rf_rs3;

  fp_fwd_ctrl fp_fwd_ctrl_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_stall           (i_stall),
    .i_flush           (i_flush),
    .i_load_use_stall  (i_load_use_stall),
    .i_load_ma_stall   (i_load_ma_stall),
    .i_pd_rs1          (i_pd_rs1),
    .i_pd_rs2          (i_pd_rs2),
    .i_pd_rs3          (i_pd_rs3),
    .i_ex_fp_we        (i_ex_fp_we),
    .i_ex_is_fp_load   (i_ex_is_fp_load),
    .i_ex_dest         (i_ex_dest),
    .i_ma_fp_we        (i_ma_fp_we),
    .i_ma_is_fp_load   (i_ma_is_fp_load),
    .i_ma_dest         (i_ma_dest),
    .i_ma_load_valid   (i_ma_load_valid),
    .o_ma_fwd          (ma_fwd),
    .o_wb_fwd          (wb_fwd),
    .o_stage1_en       (stage1_en),
    .o_stage1_sel_load (stage1_sel_load),
    .o_pending         (pending),
    .o_load_use_q      (load_use_q),
    .o_cap_en          (cap_en),
    .o_cap_valid       (cap_valid)
  );

  fp_fwd_data_pipe #(.FLEN(FLEN)) fp_fwd_data_pipe_i (
    .i_clk             (i_clk),
    .i_rst_n           (i_rst_n),
    .i_stage1_en       (stage1_en),
    .i_stage1_sel_load (stage1_sel_load),
    .i_pending         (pending),
    .i_cap_en          (cap_en),
    .i_ex_result       (i_ex_result),
    .i_ma_load_data    (i_ma_load_data),
    .i_ma_dest         (i_ma_dest),
    .o_stage2_data     (stage2_data),
    .o_cap_dest        (cap_dest),
    .o_cap_data        (cap_data)
  );

  // ==============================
  // One selector per source
  // ==============================
  for (genvar k = 0; k < 3; k++) begin : g_sel
    fp_fwd_operand_sel #(.FLEN(FLEN)) fp_fwd_operand_sel_i (
      .i_addr          (src_addr[k]),
      .i_ma_fwd        (ma_fwd[k]),
      .i_wb_fwd        (wb_fwd[k]),
      .i_load_use_q    (load_use_q),
      .i_cap_valid     (cap_valid),
      .i_cap_dest      (cap_dest),
      .i_cap_data      (cap_data),
      .i_stage2_data   (stage2_data),
      .i_ma_fp_we      (i_ma_fp_we),
      .i_ma_is_fp_load (i_ma_is_fp_load),
      .i_ma_dest       (i_ma_dest),
      .i_ma_result     (i_ma_result),
      .i_ma_load_data  (i_ma_load_data),
      .i_wb_dest       (i_wb_dest),
      .i_wb_data       (i_wb_data),
      .i_rf_data       (rf_data[k]),
      .o_value         (op_value[k])
    );
  end

  assign o_rs1_value = op_value[0];
  assign o_rs2_value = op_value[1];
  assign o_rs3_value = op_value[2];

  // Pipeline holds for one cycle while stage 2 catches up
  assign o_fwd_stall = pending;

endmodule

//--- sim/fp_fwd_tb.sv
// ==============================
// FP forwarding unit testbench
// Random hazards checked cycle by cycle against a reference model
// ==============================
`timescale 1ns/100ps

module fp_fwd_tb import fp_fwd_pkg::*; ();

  localparam int unsigned TB_FLEN    = 32;
  localparam int unsigned CLK_PERIOD = 20;
  localparam int unsigned RST_CYCLES = 5;
  localparam int unsigned NUM_CYCLES = 3000;
  localparam int unsigned MARGIN     = 200;
  localparam int unsigned SEED       = 86247;

  logic clk;
  logic rst_n;
  logic stall;
  logic flush;
  logic load_use_stall;
  logic load_ma_stall;
  fp_reg_addr_t pd_rs1;
  fp_reg_addr_t pd_rs2;
  fp_reg_addr_t pd_rs3;
  logic [INSTR_W-1:0] ex_instr;
  logic [TB_FLEN-1:0] ex_rf_rs1;
  logic [TB_FLEN-1:0] ex_rf_rs2;
  logic [TB_FLEN-1:0] ex_rf_rs3;
  logic ex_fp_we;
  logic ex_is_fp_load;
  fp_reg_addr_t ex_dest;
  logic [TB_FLEN-1:0] ex_result;
  logic ma_fp_we;
  logic ma_is_fp_load;
  fp_reg_addr_t ma_dest;
  logic [TB_FLEN-1:0] ma_result;
  logic [TB_FLEN-1:0] ma_load_data;
  logic ma_load_valid;
  fp_reg_addr_t wb_dest;
  logic [TB_FLEN-1:0] wb_data;
  logic [TB_FLEN-1:0] rs1_value;
  logic [TB_FLEN-1:0] rs2_value;
  logic [TB_FLEN-1:0] rs3_value;
  logic fwd_stall;

  // Reference model state, advanced once per rising edge
  logic [2:0] m_ma_fwd;
  logic [2:0] m_wb_fwd;
  logic [TB_FLEN-1:0] m_stage1;
  logic [TB_FLEN-1:0] m_stage2;
  logic m_pending;
  logic m_load_use_q;
  logic m_cap_valid;
  logic m_cap_clear;
  fp_reg_addr_t m_cap_dest;
  logic [TB_FLEN-1:0] m_cap_data;

  logic prev_stall;
  int error_count;
  int check_count;

  fp_fwd_unit #(.FLEN(TB_FLEN)) fp_fwd_unit_i (
    .i_clk (clk), .i_rst_n (rst_n),
    .i_stall (stall), .i_flush (flush),
    .i_load_use_stall (load_use_stall), .i_load_ma_stall (load_ma_stall),
    .i_pd_rs1 (pd_rs1), .i_pd_rs2 (pd_rs2), .i_pd_rs3 (pd_rs3),
    .i_ex_instr (ex_instr),
    .i_ex_rf_rs1 (ex_rf_rs1), .i_ex_rf_rs2 (ex_rf_rs2), .i_ex_rf_rs3 (ex_rf_rs3),
    .i_ex_fp_we (ex_fp_we), .i_ex_is_fp_load (ex_is_fp_load),
    .i_ex_dest (ex_dest), .i_ex_result (ex_result),
    .i_ma_fp_we (ma_fp_we), .i_ma_is_fp_load (ma_is_fp_load),
    .i_ma_dest (ma_dest), .i_ma_result (ma_result),
    .i_ma_load_data (ma_load_data), .i_ma_load_valid (ma_load_valid),
    .i_wb_dest (wb_dest), .i_wb_data (wb_data),
    .o_rs1_value (rs1_value), .o_rs2_value (rs2_value), .o_rs3_value (rs3_value),
    .o_fwd_stall (fwd_stall)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==============================
  // Stimulus
  // ==============================
  // Addresses stay within 0 to 3 so that hazards are frequent
  function automatic fp_reg_addr_t rand_addr();
    return fp_reg_addr_t'($urandom_range(3, 0));
  endfunction

  task automatic clear_inputs();
    {stall, flush, load_use_stall, load_ma_stall} = '0;
    {pd_rs1, pd_rs2, pd_rs3, ex_instr} = '0;
    {ex_rf_rs1, ex_rf_rs2, ex_rf_rs3} = '0;
    {ex_fp_we, ex_is_fp_load, ex_dest, ex_result} = '0;
    {ma_fp_we, ma_is_fp_load, ma_dest, ma_result} = '0;
    {ma_load_data, ma_load_valid, wb_dest, wb_data} = '0;
  endtask

  task automatic drive_random_inputs();
    stall          = ($urandom_range(3, 0) == 0);
    flush          = ($urandom_range(9, 0) == 0);
    load_use_stall = ($urandom_range(4, 0) == 0);
    load_ma_stall  = ($urandom_range(4, 0) == 0);
    pd_rs1 = rand_addr();
    pd_rs2 = rand_addr();
    pd_rs3 = rand_addr();
    // Random word with independent rs1, rs2 and rs3 fields
    ex_instr        = $urandom;
    ex_instr[19:15] = rand_addr();
    ex_instr[24:20] = rand_addr();
    ex_instr[31:27] = rand_addr();
    ex_rf_rs1 = $urandom;
    ex_rf_rs2 = $urandom;
    ex_rf_rs3 = $urandom;
    ex_fp_we      = $urandom_range(1, 0);
    ex_is_fp_load = ($urandom_range(2, 0) == 0);
    ex_dest       = rand_addr();
    ex_result     = $urandom;
    ma_fp_we      = $urandom_range(1, 0);
    ma_is_fp_load = ($urandom_range(2, 0) == 0);
    ma_dest       = rand_addr();
    ma_result     = $urandom;
    ma_load_data  = $urandom;
    ma_load_valid = $urandom_range(1, 0);
    wb_dest = rand_addr();
    wb_data = $urandom;
  endtask

  // ==============================
  // Reference model
  // ==============================
  task automatic update_model();
    fp_reg_addr_t pd [3];
    logic sel_load;
    logic s1_en;
    logic cap_en;
    pd[0] = pd_rs1;
    pd[1] = pd_rs2;
    pd[2] = pd_rs3;
    sel_load = load_use_stall && ma_is_fp_load;
    s1_en    = sel_load || (!stall && ex_fp_we);
    cap_en   = ma_is_fp_load && ma_load_valid;
    // Flags move when the pipe advances or while a load in MA holds ID
    if (flush) begin
      m_ma_fwd = '0;
      m_wb_fwd = '0;
    end else if (!stall || load_ma_stall) begin
      for (int k = 0; k < 3; k++) begin
        if (load_ma_stall)
          m_ma_fwd[k] = ma_is_fp_load && (ma_dest == pd[k]);
        else
          m_ma_fwd[k] = (ex_fp_we || ex_is_fp_load) && (ex_dest == pd[k]);
        m_wb_fwd[k] = ma_fp_we && (ma_dest == pd[k]);
      end
    end
    // Stage 2 takes the old stage 1 before stage 1 is refilled
    if (m_pending)
      m_stage2 = m_stage1;
    if (s1_en)
      m_stage1 = sel_load ? ma_load_data : ex_result;
    if (m_pending)
      m_pending = 1'b0;
    else if (s1_en)
      m_pending = 1'b1;
    m_load_use_q = load_use_stall;
    if (cap_en) begin
      m_cap_valid = 1'b1;
      m_cap_clear = 1'b0;
      m_cap_dest  = ma_dest;
      m_cap_data  = ma_load_data;
    end else if (m_cap_valid) begin
      if (m_cap_clear) begin
        m_cap_valid = 1'b0;
        m_cap_clear = 1'b0;
      end else if (!stall) begin
        m_cap_clear = 1'b1;
      end
    end
  endtask

  // First matching source wins, the register file is the fallback
  function automatic logic [TB_FLEN-1:0] predict_operand(
      fp_reg_addr_t a, logic ma_fwd, logic wb_fwd, logic [TB_FLEN-1:0] rf);
    if (ma_is_fp_load && ma_dest == a)
      return m_load_use_q ? m_stage2 : ma_load_data;
    if (ma_fp_we && !ma_is_fp_load && ma_dest == a)
      return ma_result;
    if (ma_fwd && ma_dest == a)
      return m_stage2;
    if (wb_fwd && wb_dest == a)
      return wb_data;
    if (m_cap_valid && m_cap_dest == a)
      return m_cap_data;
    return rf;
  endfunction

  // ==============================
  // Checking
  // ==============================
  task automatic check_value(logic [TB_FLEN-1:0] actual, logic [TB_FLEN-1:0] expected,
      string msg);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("FAILED at %0t: %s got %h expected %h", $time, msg, actual, expected);
    end
  endtask

  task automatic check_outputs();
    check_value(rs1_value, predict_operand(ex_instr[19:15], m_ma_fwd[0], m_wb_fwd[0],
      ex_rf_rs1), "rs1 operand");
    check_value(rs2_value, predict_operand(ex_instr[24:20], m_ma_fwd[1], m_wb_fwd[1],
      ex_rf_rs2), "rs2 operand");
    // rs3 sits in the top five bits of the R4 format
    check_value(rs3_value, predict_operand(ex_instr[31:27], m_ma_fwd[2], m_wb_fwd[2],
      ex_rf_rs3), "rs3 operand");
    check_value(fwd_stall, m_pending, "forwarding stall");
    check_value(prev_stall && fwd_stall, 1'b0, "forwarding stall on two cycles");
    prev_stall = fwd_stall;
  endtask

  initial begin
    void'($urandom(SEED));
    error_count = 0;
    check_count = 0;
    prev_stall = 1'b0;
    {m_ma_fwd, m_wb_fwd, m_stage1, m_stage2, m_pending, m_load_use_q} = '0;
    {m_cap_valid, m_cap_clear, m_cap_dest, m_cap_data} = '0;
    clear_inputs();
    rst_n = 1'b0;
    repeat (RST_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    // Random traffic across the last reset edge must not disturb the idle state
    drive_random_inputs();
    @(posedge clk);
    #(CLK_PERIOD / 2 - 1);
    check_outputs();
    @(negedge clk);
    rst_n = 1'b1;
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_random_inputs();
      @(posedge clk);
      update_model();
      // Outputs are sampled just before the next falling edge
      #(CLK_PERIOD / 2 - 1);
      check_outputs();
      @(negedge clk);
    end
    $display("Run complete: %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Watchdog covering the full random run plus a margin
  initial begin
    #((NUM_CYCLES + MARGIN) * CLK_PERIOD);
    $display("Watchdog: the run timed out before all cycles were checked");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

//--- vlog.f
rtl/fp_fwd_pkg.sv
rtl/fp_fwd_ctrl.sv
rtl/fp_fwd_data_pipe.sv
rtl/fp_fwd_operand_sel.sv
rtl/fp_fwd_unit.sv
sim/fp_fwd_tb.sv
